//--- src/rooth_pkg.sv
// shared types for the cut-down soc; word-aligned accesses only, no byte enables on the bus
package rooth_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [15:0] gpio_t;

    // ------------------------------
    // rv32i opcodes in use
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    // ------------------------------
    // address map, region is addr[31:28]
    localparam logic [3:0] REGION_INST = 4'h0;
    localparam logic [3:0] REGION_DATA = 4'h1;
    localparam logic [3:0] REGION_GPIO = 4'h4;

    localparam logic [7:0] GPIO_CTRL_OFS = 8'h00;
    localparam logic [7:0] GPIO_DATA_OFS = 8'h04;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  we;
        logic  req;
    } bus_req_t;

    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_PASS} alu_op_t;
    typedef enum logic [1:0] {WB_NONE, WB_ALU, WB_LOAD, WB_LINK} wb_sel_t;

    typedef struct packed {
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     imm;
        alu_op_t   alu_op;
        logic      use_imm;
        wb_sel_t   wb_sel;
        logic      mem_read;
        logic      mem_write;
        logic      branch;
        logic      branch_ne;
        logic      jump;
    } dec_t;

    typedef struct packed {
        word_t alu;
        logic  branch_taken;
        word_t target;
    } exe_t;

    typedef enum logic [2:0] {ST_FETCH, ST_DECODE, ST_EXEC, ST_MEM, ST_WB} core_state_t;

endpackage

//--- src/rooth_ram.sv
// word RAM with registered read; addr bits 1:0 are ignored, contents are undefined at power-up
`timescale 1ns/100ps

module rooth_ram #(
    parameter int DEPTH_LOG2 = 8
) (
    input  logic                clk_i,
    input  rooth_pkg::bus_req_t req_i,
    output rooth_pkg::word_t    rdata_o
);
    import rooth_pkg::*;

    word_t                  mem [2**DEPTH_LOG2];
    logic [DEPTH_LOG2-1:0]  idx;

    assign idx = req_i.addr[DEPTH_LOG2+1:2];

    always_ff @(posedge clk_i) begin
        if (req_i.req && req_i.we) begin
            mem[idx] <= req_i.wdata;
        end
        if (req_i.req && !req_i.we) begin
            rdata_o <= mem[idx];
        end
    end

    // nothing may sit between the region field and the word index
    a_addr_in_range: assert property (@(posedge clk_i)
        req_i.req |-> req_i.addr[27:DEPTH_LOG2+2] == '0);

endmodule

//--- src/rooth_decode.sv
// decode for the supported rv32i subset only; anything else becomes a no-op
`timescale 1ns/100ps

module rooth_decode (
    input  rooth_pkg::word_t inst_i,
    output rooth_pkg::dec_t  dec_o
);
    import rooth_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    // ------------------------------
    // immediates, all sign-extended
    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                    inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                    inst_i[30:21], 1'b0};

    always_comb begin
        dec_o     = '0;
        dec_o.rs1 = inst_i[19:15];
        dec_o.rs2 = inst_i[24:20];
        dec_o.rd  = inst_i[11:7];
        case (opcode)
            OP_IMM: begin
                // addi only
                if (funct3 == 3'b000) begin
                    dec_o.imm     = imm_i;
                    dec_o.use_imm = 1'b1;
                    dec_o.wb_sel  = WB_ALU;
                end
            end
            OP_REG: begin
                dec_o.wb_sel = WB_ALU;
                case (funct3)
                    3'b000:  dec_o.alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b100:  dec_o.alu_op = ALU_XOR;
                    3'b110:  dec_o.alu_op = ALU_OR;
                    3'b111:  dec_o.alu_op = ALU_AND;
                    default: dec_o.wb_sel = WB_NONE;
                endcase
            end
            OP_LUI: begin
                dec_o.imm     = imm_u;
                dec_o.use_imm = 1'b1;
                dec_o.alu_op  = ALU_PASS;
                dec_o.wb_sel  = WB_ALU;
            end
            OP_LOAD: begin
                if (funct3 == 3'b010) begin
                    dec_o.imm      = imm_i;
                    dec_o.use_imm  = 1'b1;
                    dec_o.mem_read = 1'b1;
                    dec_o.wb_sel   = WB_LOAD;
                end
            end
            OP_STORE: begin
                if (funct3 == 3'b010) begin
                    dec_o.imm       = imm_s;
                    dec_o.use_imm   = 1'b1;
                    dec_o.mem_write = 1'b1;
                end
            end
            OP_BRANCH: begin
                // beq and bne only
                if (funct3[2:1] == 2'b00) begin
                    dec_o.imm       = imm_b;
                    dec_o.branch    = 1'b1;
                    dec_o.branch_ne = funct3[0];
                end
            end
            OP_JAL: begin
                dec_o.imm    = imm_j;
                dec_o.jump   = 1'b1;
                dec_o.wb_sel = WB_LINK;
            end
            default: dec_o.wb_sel = WB_NONE;
        endcase
    end

endmodule

//--- src/rooth_execute.sv
// single-cycle ALU and branch resolution; no shifts, no compares beyond equality
`timescale 1ns/100ps

module rooth_execute (
    input  rooth_pkg::dec_t  dec_i,
    input  rooth_pkg::word_t pc_i,
    input  rooth_pkg::word_t rs1_data_i,
    input  rooth_pkg::word_t rs2_data_i,
    output rooth_pkg::exe_t  exe_o
);
    import rooth_pkg::*;

    word_t op_b;
    word_t result;
    logic  equal;

    assign op_b  = dec_i.use_imm ? dec_i.imm : rs2_data_i;
    assign equal = (rs1_data_i == rs2_data_i);

    // ------------------------------
    // the alu also forms the load/store address
    always_comb begin
        case (dec_i.alu_op)
            ALU_ADD:  result = rs1_data_i + op_b;
            ALU_SUB:  result = rs1_data_i - op_b;
            ALU_AND:  result = rs1_data_i & op_b;
            ALU_OR:   result = rs1_data_i | op_b;
            ALU_XOR:  result = rs1_data_i ^ op_b;
            ALU_PASS: result = op_b;
            default:  result = '0;
        endcase
    end

    assign exe_o.alu    = result;
    assign exe_o.target = pc_i + dec_i.imm;

    // jal is always taken; bne inverts the equality test
    assign exe_o.branch_taken = dec_i.jump | (dec_i.branch & (equal ^ dec_i.branch_ne));

endmodule

//--- src/rooth_result.sv
// register file with x0 tied to zero; flags follow x26/x27 bit 0 one cycle late
`timescale 1ns/100ps

module rooth_result (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  logic                 clr_i,
    input  logic                 we_i,
    input  rooth_pkg::reg_addr_t rd_i,
    input  rooth_pkg::wb_sel_t   wb_sel_i,
    input  rooth_pkg::word_t     alu_i,
    input  rooth_pkg::word_t     load_i,
    input  rooth_pkg::word_t     link_i,
    input  rooth_pkg::reg_addr_t rs1_i,
    input  rooth_pkg::reg_addr_t rs2_i,
    output rooth_pkg::word_t     rs1_data_o,
    output rooth_pkg::word_t     rs2_data_o,
    output logic                 over_o,
    output logic                 succ_o
);
    import rooth_pkg::*;

    word_t regs_q [1:31];
    word_t wb_data;

    always_comb begin
        case (wb_sel_i)
            WB_LOAD: wb_data = load_i;
            WB_LINK: wb_data = link_i;
            default: wb_data = alu_i;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            regs_q <= '{default: '0};
            over_o <= 1'b0;
            succ_o <= 1'b0;
        end else if (clr_i) begin
            regs_q <= '{default: '0};
            over_o <= 1'b0;
            succ_o <= 1'b0;
        end else begin
            if (we_i && rd_i != '0) begin
                regs_q[rd_i] <= wb_data;
            end
            over_o <= regs_q[26][0];
            succ_o <= regs_q[27][0];
        end
    end

    assign rs1_data_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

    // the core must only request a write for instructions that produce a value
    a_no_blind_write: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        we_i |-> wb_sel_i != WB_NONE);

endmodule

//--- src/rooth_core.sv
// multi-cycle core, 4 to 6 cycles per instruction; no interrupts, no csr, no misalign traps
`timescale 1ns/100ps

module rooth_core #(
    parameter rooth_pkg::word_t RESET_PC = '0
) (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                core_rst_i,
    input  logic                hold_i,
    output rooth_pkg::bus_req_t bus_o,
    input  rooth_pkg::word_t    rdata_i,
    output logic                over_o,
    output logic                succ_o
);
    import rooth_pkg::*;

    core_state_t state_q;
    word_t       pc_q;
    word_t       pc_plus4;
    dec_t        dec_d;
    dec_t        dec_q;
    exe_t        exe_d;
    exe_t        exe_q;
    word_t       load_q;
    logic        mem_wait_q;
    logic        rf_we;
    word_t       rs1_data;
    word_t       rs2_data;

    assign pc_plus4 = pc_q + 32'd4;

    // decode straight from the fetch data while in ST_DECODE
    rooth_decode u_decode (
        .inst_i ( rdata_i ),
        .dec_o  ( dec_d   )
    );

    rooth_execute u_execute (
        .dec_i      ( dec_q    ),
        .pc_i       ( pc_q     ),
        .rs1_data_i ( rs1_data ),
        .rs2_data_i ( rs2_data ),
        .exe_o      ( exe_d    )
    );

    assign rf_we = (state_q == ST_WB) && !hold_i && (dec_q.wb_sel != WB_NONE);

    rooth_result u_result (
        .clk_i      ( clk_i        ),
        .arst_n_i   ( arst_n_i     ),
        .clr_i      ( core_rst_i   ),
        .we_i       ( rf_we        ),
        .rd_i       ( dec_q.rd     ),
        .wb_sel_i   ( dec_q.wb_sel ),
        .alu_i      ( exe_q.alu    ),
        .load_i     ( load_q       ),
        .link_i     ( pc_plus4     ),
        .rs1_i      ( dec_q.rs1    ),
        .rs2_i      ( dec_q.rs2    ),
        .rs1_data_o ( rs1_data     ),
        .rs2_data_o ( rs2_data     ),
        .over_o     ( over_o       ),
        .succ_o     ( succ_o       )
    );

    // ------------------------------
    // control fsm
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= ST_FETCH;
            pc_q       <= RESET_PC;
            dec_q      <= '0;
            exe_q      <= '0;
            mem_wait_q <= 1'b0;
        end else if (core_rst_i) begin
            state_q    <= ST_FETCH;
            pc_q       <= RESET_PC;
            dec_q      <= '0;
            exe_q      <= '0;
            mem_wait_q <= 1'b0;
        end else if (!hold_i) begin
            case (state_q)
                ST_FETCH:  state_q <= ST_DECODE;
                ST_DECODE: begin
                    dec_q   <= dec_d;
                    state_q <= ST_EXEC;
                end
                ST_EXEC: begin
                    exe_q   <= exe_d;
                    state_q <= (dec_q.mem_read || dec_q.mem_write) ? ST_MEM : ST_WB;
                end
                ST_MEM: begin
                    // loads wait one more cycle for the read data
                    if (dec_q.mem_read && !mem_wait_q) begin
                        mem_wait_q <= 1'b1;
                    end else begin
                        mem_wait_q <= 1'b0;
                        state_q    <= ST_WB;
                    end
                end
                ST_WB: begin
                    pc_q    <= exe_q.branch_taken ? exe_q.target : pc_plus4;
                    state_q <= ST_FETCH;
                end
                default: state_q <= ST_FETCH;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == ST_MEM && mem_wait_q) begin
            load_q <= rdata_i;
        end
    end

    // ------------------------------
    // bus master
    always_comb begin
        bus_o = '0;
        if (state_q == ST_FETCH) begin
            bus_o.addr = pc_q;
            bus_o.req  = 1'b1;
        end else if (state_q == ST_MEM && !mem_wait_q) begin
            bus_o.addr  = exe_q.alu;
            bus_o.wdata = rs2_data;
            bus_o.we    = dec_q.mem_write;
            bus_o.req   = 1'b1;
        end
    end

    // a store reaches the bus only in the cycle after EXEC, or again while held
    a_write_only_in_mem: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        bus_o.we |-> state_q == ST_MEM && ($past(state_q) == ST_EXEC || $past(hold_i)));

endmodule

//--- src/rooth_rib.sv
// two masters, three slaves; loader always wins and the core is held, no ready handshake
`timescale 1ns/100ps

module rooth_rib (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  rooth_pkg::bus_req_t core_req_i,
    input  rooth_pkg::bus_req_t load_req_i,
    output rooth_pkg::word_t    core_rdata_o,
    output rooth_pkg::bus_req_t inst_req_o,
    output rooth_pkg::bus_req_t data_req_o,
    output rooth_pkg::bus_req_t gpio_req_o,
    input  rooth_pkg::word_t    inst_rdata_i,
    input  rooth_pkg::word_t    data_rdata_i,
    input  rooth_pkg::word_t    gpio_rdata_i,
    output logic                hold_o
);
    import rooth_pkg::*;

    bus_req_t   sel_req;
    logic [3:0] region;
    logic [3:0] region_q;

    assign hold_o  = load_req_i.req;
    assign sel_req = load_req_i.req ? load_req_i : core_req_i;
    assign region  = sel_req.addr[31:28];

    // ------------------------------
    // slave select
    always_comb begin
        inst_req_o = '0;
        data_req_o = '0;
        gpio_req_o = '0;
        case (region)
            REGION_INST: inst_req_o = sel_req;
            REGION_DATA: data_req_o = sel_req;
            REGION_GPIO: gpio_req_o = sel_req;
            default: ;
        endcase
    end

    // region of the access whose data comes back next cycle
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            region_q <= REGION_INST;
        end else if (sel_req.req) begin
            region_q <= region;
        end
    end

    always_comb begin
        case (region_q)
            REGION_INST: core_rdata_o = inst_rdata_i;
            REGION_DATA: core_rdata_o = data_rdata_i;
            REGION_GPIO: core_rdata_o = gpio_rdata_i;
            default:     core_rdata_o = '0;
        endcase
    end

endmodule

//--- src/rooth_gpio.sv
// 16 pins, 2-bit control per pin (01 drives); pads and tristates live outside this block
`timescale 1ns/100ps

module rooth_gpio (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  rooth_pkg::bus_req_t req_i,
    output rooth_pkg::word_t    rdata_o,
    input  rooth_pkg::gpio_t    gpio_i,
    output rooth_pkg::gpio_t    gpio_o,
    output rooth_pkg::gpio_t    gpio_oe_o
);
    import rooth_pkg::*;

    word_t ctrl_q;
    gpio_t data_q;
    gpio_t pin_val;

    // per-pin output enable
    always_comb begin
        for (int i = 0; i < 16; i++) begin
            gpio_oe_o[i] = (ctrl_q[2*i +: 2] == 2'b01);
        end
    end

    assign gpio_o  = data_q;
    assign pin_val = (data_q & gpio_oe_o) | (gpio_i & ~gpio_oe_o);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ctrl_q <= '0;
            data_q <= '0;
        end else if (req_i.req && req_i.we) begin
            if (req_i.addr[7:0] == GPIO_CTRL_OFS) begin
                ctrl_q <= req_i.wdata;
            end
            if (req_i.addr[7:0] == GPIO_DATA_OFS) begin
                data_q <= req_i.wdata[15:0];
            end
        end
    end

    // inputs are sampled by the registered read
    always_ff @(posedge clk_i) begin
        if (req_i.req && !req_i.we) begin
            case (req_i.addr[7:0])
                GPIO_CTRL_OFS: rdata_o <= ctrl_q;
                GPIO_DATA_OFS: rdata_o <= {16'b0, pin_val};
                default:       rdata_o <= '0;
            endcase
        end
    end

endmodule

//--- src/rooth_soc.sv
// soc top; the loader port must write only while it holds the bus, core_rst_i restarts the core
`timescale 1ns/100ps

module rooth_soc #(
    parameter int               INST_DEPTH_LOG2 = 8,
    parameter int               DATA_DEPTH_LOG2 = 8,
    parameter rooth_pkg::word_t RESET_PC        = '0
) (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  rooth_pkg::bus_req_t load_req_i,
    input  logic                core_rst_i,
    input  rooth_pkg::gpio_t    gpio_i,
    output rooth_pkg::gpio_t    gpio_o,
    output rooth_pkg::gpio_t    gpio_oe_o,
    output logic                over_o,
    output logic                succ_o
);
    import rooth_pkg::*;

    bus_req_t core_req;
    word_t    core_rdata;
    logic     hold;
    bus_req_t inst_req;
    bus_req_t data_req;
    bus_req_t gpio_req;
    word_t    inst_rdata;
    word_t    data_rdata;
    word_t    gpio_rdata;

    rooth_core #(
        .RESET_PC ( RESET_PC )
    ) u_core (
        .clk_i      ( clk_i      ),
        .arst_n_i   ( arst_n_i   ),
        .core_rst_i ( core_rst_i ),
        .hold_i     ( hold       ),
        .bus_o      ( core_req   ),
        .rdata_i    ( core_rdata ),
        .over_o     ( over_o     ),
        .succ_o     ( succ_o     )
    );

    rooth_rib u_rib (
        .clk_i        ( clk_i      ),
        .arst_n_i     ( arst_n_i   ),
        .core_req_i   ( core_req   ),
        .load_req_i   ( load_req_i ),
        .core_rdata_o ( core_rdata ),
        .inst_req_o   ( inst_req   ),
        .data_req_o   ( data_req   ),
        .gpio_req_o   ( gpio_req   ),
        .inst_rdata_i ( inst_rdata ),
        .data_rdata_i ( data_rdata ),
        .gpio_rdata_i ( gpio_rdata ),
        .hold_o       ( hold       )
    );

    // ------------------------------
    // slaves
    rooth_ram #(
        .DEPTH_LOG2 ( INST_DEPTH_LOG2 )
    ) u_inst_ram (
        .clk_i   ( clk_i      ),
        .req_i   ( inst_req   ),
        .rdata_o ( inst_rdata )
    );

    rooth_ram #(
        .DEPTH_LOG2 ( DATA_DEPTH_LOG2 )
    ) u_data_ram (
        .clk_i   ( clk_i      ),
        .req_i   ( data_req   ),
        .rdata_o ( data_rdata )
    );

    rooth_gpio u_gpio (
        .clk_i     ( clk_i      ),
        .arst_n_i  ( arst_n_i   ),
        .req_i     ( gpio_req   ),
        .rdata_o   ( gpio_rdata ),
        .gpio_i    ( gpio_i     ),
        .gpio_o    ( gpio_o     ),
        .gpio_oe_o ( gpio_oe_o  )
    );

endmodule

//--- tb/rooth_tb_prog.svh
// test programs of up to 16 words at address 0, each ending in a jump-to-self loop
`ifndef ROOTH_TB_PROG_SVH
`define ROOTH_TB_PROG_SVH

localparam int NUM_PROGS = 7;

typedef struct packed {
    logic [63:0]       name;
    logic [15:0][31:0] words;
    logic [4:0]        len;
    gpio_t             gpio_in;
    logic              exp_succ;
    gpio_t             exp_gpio;
    gpio_t             exp_oe;
    logic              overlap;
} prog_t;

prog_t progs [NUM_PROGS];
prog_t decoy;

// 01 drives a pin, the others get 10 or 11 which must not enable it
function automatic word_t ctrl_for(gpio_t mask);
    word_t c;
    c = '0;
    for (int i = 0; i < 16; i++) begin
        c[2*i +: 2] = mask[i] ? 2'b01 : {1'b1, i[0]};
    end
    return c;
endfunction

task automatic emit_gpio_write(input gpio_t mask, input gpio_t data);
    emit(lui_op(5'd1, 20'h40000));
    load_const(5'd2, ctrl_for(mask));
    emit(sw_op(5'd2, 5'd1, 12'h000));
    load_const(5'd3, {16'b0, data});
    emit(sw_op(5'd3, 5'd1, 12'h004));
endtask

task automatic build_table();
    word_t a;
    word_t b;
    word_t c;
    word_t r;
    // ------------------------------
    // a mismatch in the alu chain skips the x27 write
    for (int k = 0; k < 2; k++) begin
        a = next_rand();
        b = next_rand();
        r = next_rand();
        c = {{20{r[11]}}, r[11:0]};
        load_const(5'd1, a);
        load_const(5'd2, b);
        emit(reg_op(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
        emit(reg_op(7'h00, 3'b100, 5'd3, 5'd3, 5'd1));
        emit(reg_op(7'h20, 3'b000, 5'd3, 5'd3, 5'd2));
        emit(reg_op(7'h00, 3'b110, 5'd3, 5'd3, 5'd1));
        emit(reg_op(7'h00, 3'b111, 5'd3, 5'd3, 5'd2));
        emit(addi_op(5'd3, 5'd3, c[11:0]));
        load_const(5'd4, (((((a + b) ^ a) - b) | a) & b) + c);
        emit(branch_op(1'b1, 5'd3, 5'd4, 8));
        emit_flags();
        take_program(progs[k], k == 0 ? "alu_ch_1" : "alu_ch_2", '0, 1'b1, '0, '0, 1'b0);
    end

    // store and load back through the data RAM
    r = next_rand();
    load_const(5'd1, r);
    emit(lui_op(5'd2, 20'h10000));
    emit(sw_op(5'd1, 5'd2, 12'd8));
    emit(lw_op(5'd3, 5'd2, 12'd8));
    emit(branch_op(1'b0, 5'd1, 5'd3, 8));
    emit(jal_op(5'd0, 8));
    emit_flags();
    take_program(progs[2], "mem_rdbk", '0, 1'b1, '0, '0, 1'b0);

    // bne not taken, bne taken, jal with link check; word 7 is the wrong path
    emit(addi_op(5'd1, 5'd0, 12'd5));
    emit(addi_op(5'd2, 5'd0, 12'd5));
    emit(branch_op(1'b1, 5'd1, 5'd2, 20));
    emit(addi_op(5'd2, 5'd2, 12'd1));
    emit(branch_op(1'b1, 5'd1, 5'd2, 8));
    emit(jal_op(5'd0, 8));
    emit(jal_op(5'd5, 12));
    emit(addi_op(5'd26, 5'd0, 12'd1));
    emit(jal_op(5'd0, 0));
    emit(addi_op(5'd6, 5'd0, 12'd28));
    emit(branch_op(1'b1, 5'd5, 5'd6, -12));
    emit_flags();
    take_program(progs[3], "br_jal_p", '0, 1'b1, '0, '0, 1'b0);

    // ------------------------------
    // gpio output, then input pins read back and written out
    r = next_rand();
    emit_gpio_write(r[15:0], r[31:16]);
    emit_flags();
    take_program(progs[4], "gpio_out", '0, 1'b1, r[31:16], r[15:0], 1'b0);

    r = next_rand();
    emit(lui_op(5'd1, 20'h40000));
    load_const(5'd2, ctrl_for(r[15:0]));
    emit(sw_op(5'd2, 5'd1, 12'h000));
    emit(sw_op(5'd0, 5'd1, 12'h004));
    emit(lw_op(5'd3, 5'd1, 12'h004));
    emit(sw_op(5'd3, 5'd1, 12'h004));
    emit_flags();
    take_program(progs[5], "gpio_inp", r[31:16], 1'b1, r[31:16] & ~r[15:0], r[15:0], 1'b0);

    // loaded over the decoy while it counts down
    r = next_rand();
    emit_gpio_write(r[15:0], r[31:16]);
    emit_flags();
    take_program(progs[6], "hold_new", '0, 1'b1, r[31:16], r[15:0], 1'b1);

    // would drive all pins high with succ_o low if it ever finished
    emit(lui_op(5'd1, 20'h40000));
    emit(addi_op(5'd5, 5'd0, 12'd1000));
    emit(addi_op(5'd5, 5'd5, 12'hfff));
    emit(branch_op(1'b1, 5'd5, 5'd0, -4));
    emit(addi_op(5'd6, 5'd0, 12'hfff));
    emit(sw_op(5'd6, 5'd1, 12'h004));
    emit(addi_op(5'd26, 5'd0, 12'd1));
    emit(jal_op(5'd0, 0));
    take_program(decoy, "decoy_pg", '0, 1'b0, '0, '0, 1'b0);
endtask

`endif

//--- tb/rooth_tb.sv
// self-checking testbench; programs are loaded from address 0, so RESET_PC must stay 0
`timescale 1ns/100ps

module rooth_tb;
    import rooth_pkg::*;

    logic     clk;
    logic     arst_n;
    bus_req_t load_req;
    logic     core_rst;
    gpio_t    gpio_in;
    gpio_t    gpio_out;
    gpio_t    gpio_oe;
    logic     over;
    logic     succ;

    word_t    rng_state = 32'h474b_f0e0;
    word_t    asm_q [$];
    int       limit;
    string    tag;

    `include "rooth_tb_prog.svh"

    rooth_soc #(
        .INST_DEPTH_LOG2 ( 8   ),
        .DATA_DEPTH_LOG2 ( 8   ),
        .RESET_PC        ( '0  )
    ) dut (
        .clk_i      ( clk      ),
        .arst_n_i   ( arst_n   ),
        .load_req_i ( load_req ),
        .core_rst_i ( core_rst ),
        .gpio_i     ( gpio_in  ),
        .gpio_o     ( gpio_out ),
        .gpio_oe_o  ( gpio_oe  ),
        .over_o     ( over     ),
        .succ_o     ( succ     )
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ------------------------------
    // instruction encoders
    function automatic word_t addi_op(reg_addr_t rd, reg_addr_t rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, OP_IMM};
    endfunction

    function automatic word_t reg_op(logic [6:0] f7, logic [2:0] f3, reg_addr_t rd,
                                     reg_addr_t rs1, reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic word_t lui_op(reg_addr_t rd, logic [19:0] imm);
        return {imm, rd, OP_LUI};
    endfunction

    function automatic word_t lw_op(reg_addr_t rd, reg_addr_t rs1, logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, OP_LOAD};
    endfunction

    function automatic word_t sw_op(reg_addr_t rs2, reg_addr_t rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic word_t branch_op(logic ne, reg_addr_t rs1, reg_addr_t rs2, int off);
        return {off[12], off[10:5], rs2, rs1, 2'b00, ne, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic word_t jal_op(reg_addr_t rd, int off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    function automatic word_t next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    task automatic emit(input word_t w);
        asm_q.push_back(w);
    endtask

    // lui rounds up when addi will sign-extend a negative low part
    task automatic load_const(input reg_addr_t rd, input word_t v);
        word_t hi;
        hi = v + 32'h800;
        emit(lui_op(rd, hi[31:12]));
        emit(addi_op(rd, rd, v[11:0]));
    endtask

    // x27 then x26, so succ_o is settled when over_o rises
    task automatic emit_flags();
        emit(addi_op(5'd27, 5'd0, 12'd1));
        emit(addi_op(5'd26, 5'd0, 12'd1));
        emit(jal_op(5'd0, 0));
    endtask

    task automatic take_program(output prog_t p, input logic [63:0] name, input gpio_t pins,
                                input logic succ_exp, input gpio_t gpio_exp,
                                input gpio_t oe_exp, input logic overlap);
        p          = '0;
        p.name     = name;
        p.gpio_in  = pins;
        p.exp_succ = succ_exp;
        p.exp_gpio = gpio_exp;
        p.exp_oe   = oe_exp;
        p.overlap  = overlap;
        p.len      = asm_q.size();
        foreach (asm_q[i]) begin
            p.words[i] = asm_q[i];
        end
        asm_q.delete();
    endtask

    task automatic check(input string what, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("Fail %s: expected %h, actual %h", what, exp, act);
            $display("Testbench failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // ------------------------------
    // loader writes one word per cycle, then pulses the core reset
    task automatic load_and_restart(input prog_t p, input logic watch_hold);
        word_t held;
        held = '0;
        for (int i = 0; i < p.len; i++) begin
            @(posedge clk);
            load_req <= '{addr: 32'(4 * i), wdata: p.words[i], we: 1'b1, req: 1'b1};
            if (watch_hold) begin
                @(negedge clk);
                if (i == 0) begin
                    held = word_t'(dut.u_core.state_q);
                end
                check($sformatf("%s core hold", p.name), held, word_t'(dut.u_core.state_q));
            end
        end
        @(posedge clk);
        load_req <= '0;
        core_rst <= 1'b1;
        @(posedge clk);
        core_rst <= 1'b0;
    endtask

    initial begin
        wait (limit > 0);
        repeat (limit) @(posedge clk);
        $display("Timeout: over_o did not rise within %0d cycles", limit);
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        arst_n   = 1'b0;
        core_rst = 1'b0;
        load_req = '0;
        gpio_in  = '0;
        build_table();
        limit = 20 + decoy.len + 42;
        for (int i = 0; i < NUM_PROGS; i++) begin
            limit += progs[i].len + 203;
        end
        repeat (7) @(posedge clk);
        @(negedge clk);
        check("reset over_o", '0, over);
        check("reset succ_o", '0, succ);
        check("reset gpio_oe_o", '0, gpio_oe);
        @(posedge clk);
        arst_n <= 1'b1;

        for (int i = 0; i < NUM_PROGS; i++) begin
            @(posedge clk);
            gpio_in <= progs[i].gpio_in;
            if (progs[i].overlap) begin
                load_and_restart(decoy, 1'b0);
                repeat (40) @(posedge clk);
            end
            load_and_restart(progs[i], progs[i].overlap);
            do @(negedge clk); while (!over);
            tag = $sformatf("%s", progs[i].name);
            check({tag, " succ_o"}, progs[i].exp_succ, succ);
            check({tag, " gpio_o"}, progs[i].exp_gpio, gpio_out);
            check({tag, " gpio_oe_o"}, progs[i].exp_oe, gpio_oe);
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

//--- all.f
+incdir+tb
src/rooth_pkg.sv
src/rooth_ram.sv
src/rooth_decode.sv
src/rooth_execute.sv
src/rooth_result.sv
src/rooth_core.sv
src/rooth_rib.sv
src/rooth_gpio.sv
src/rooth_soc.sv
tb/rooth_tb.sv

//--- Bender.yml
package:
  name: rooth

sources:
  - src/rooth_pkg.sv
  - src/rooth_ram.sv
  - src/rooth_decode.sv
  - src/rooth_execute.sv
  - src/rooth_result.sv
  - src/rooth_core.sv
  - src/rooth_rib.sv
  - src/rooth_gpio.sv
  - src/rooth_soc.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/rooth_tb.sv
